/* Bender.yml */
package:
  name: commit_top

sources:
  - verilog/commit_pkg.sv
  - verilog/commit_ctrl_if.sv
  - verilog/commit_stage.sv
  - verilog/flush_ctrl.sv
  - verilog/perf_counters.sv
  - verilog/commit_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/commit_tb.sv

/* commit_top.f */
+incdir+verif
verilog/commit_pkg.sv
verilog/commit_ctrl_if.sv
verilog/commit_stage.sv
verilog/flush_ctrl.sv
verilog/perf_counters.sv
verilog/commit_top.sv
verif/commit_tb.sv

/* verif/commit_tb_tests.svh */
// Test tasks for commit_tb, included in its module body.
// Retired entries are counted here as the model for the counter readback.

`ifndef COMMIT_TB_TESTS_SVH
`define COMMIT_TB_TESTS_SVH

// --------------------------------------------------
// Reporting
// --------------------------------------------------
task automatic report_mismatch(string what, logic [63:0] expected, logic [63:0] actual);
  errors++;
  $display("Fail %s %s: expected %0h, actual %0h", cur_test, what, expected, actual);
endtask

task automatic fail_note(string what);
  errors++;
  $display("Error in %s: %s", cur_test, what);
endtask

task automatic abort_run(string what);
  fail_note(what);
  finish_run();
endtask

task automatic start_test(string name);
  cur_test    = name;
  test_errors = errors;
endtask

task automatic finish_test();
  tests_run++;
  if (errors != test_errors) begin
    tests_failed++;
  end
  $display("%s done, %0d errors", cur_test, errors - test_errors);
endtask

// --------------------------------------------------
// Stimulus
// --------------------------------------------------
function automatic logic [OP_W-1:0] random_op();
  case ($urandom_range(0, 2))
    0:       return OP_RESULT;
    1:       return OP_EXC;
    default: return OP_FENCE;
  endcase
endfunction

// Holds one entry at the head until it retires
task automatic commit_entry(logic [OP_W-1:0] op, logic [REG_ADDR_W-1:0] waddr,
                            logic [DATA_W-1:0] payload);
  int unsigned cycles;
  logic        acked;
  cycles    = 0;
  acked     = 1'b0;
  ack_delay = $urandom_range(0, 3);
  commit_valid_i   = 1'b1;
  commit_op_i      = op;
  commit_waddr_i   = waddr;
  commit_payload_i = payload;
  while (!acked && cycles < TimeoutCycles) begin
    @(negedge clk_i);
    acked = commit_ack_o;
    cycles++;
    @(posedge clk_i);
    #1;
  end
  commit_valid_i = 1'b0;
  if (!acked) begin
    abort_run("no commit ack within the timeout");
  end else if (op == OP_EXC) begin
    model_exc++;
  end else begin
    model_instret++;
  end
endtask

// First entry of each run writes x0
task automatic run_entries(string name, int n, logic [OP_W-1:0] op, logic mix);
  start_test(name);
  for (int i = 0; i < n; i++) begin
    commit_entry(mix ? random_op() : op,
                 (i == 0) ? '0 : REG_ADDR_W'($urandom_range(0, 31)), $urandom());
  end
  finish_test();
endtask

task automatic read_counter(logic [PERF_ADDR_W-1:0] addr, logic [CntWidth-1:0] expected);
  perf_addr_i = addr;
  chk_exp     = expected;
  chk_en      = 1'b1;
  @(posedge clk_i);
  #1;
  chk_en = 1'b0;
endtask

task automatic read_cycle(input logic [CntWidth-1:0] floor, output logic [CntWidth-1:0] value);
  perf_addr_i = PERF_CYCLE;
  cyc_floor   = floor;
  cyc_en      = 1'b1;
  @(negedge clk_i);
  value = perf_rdata_o;
  @(posedge clk_i);
  #1;
  cyc_en = 1'b0;
endtask

// --------------------------------------------------
// Tests
// --------------------------------------------------
// Cycle counter is read in the first cycle out of reset
task automatic check_reset();
  start_test("reset_state");
  perf_addr_i = PERF_CYCLE;
  chk_exp     = '0;
  chk_en      = 1'b1;
  rst_ni      = 1'b1;
  @(posedge clk_i);
  #1;
  read_counter(PERF_INSTRET, '0);
  read_counter(PERF_EXC, '0);
  finish_test();
endtask

task automatic check_counters();
  logic [CntWidth-1:0] first_cycle;
  logic [CntWidth-1:0] second_cycle;
  start_test("counter_readback");
  read_counter(PERF_INSTRET, CntWidth'(model_instret));
  read_counter(PERF_EXC, CntWidth'(model_exc));
  // Unused select reads as zero while the counters are busy
  read_counter(PERF_ADDR_W'(3), '0);
  read_cycle('0, first_cycle);
  read_cycle(first_cycle, second_cycle);
  finish_test();
endtask

`endif

/* verif/commit_tb.sv */
// Testbench for commit_top. The concurrent assertions below do all checking,
// the included tasks only present entries and read the counters.

`timescale 1ns/1ps

module commit_tb;

  import commit_pkg::*;

  localparam int unsigned CntWidth      = 32;
  localparam int unsigned TimeoutCycles = 64;

  logic                      clk_i, rst_ni, commit_valid_i, commit_ack_o;
  logic [OP_W-1:0]           commit_op_i;
  logic [REG_ADDR_W-1:0]     commit_waddr_i, waddr_o;
  logic [DATA_W-1:0]         commit_payload_i, wdata_o;
  logic                      we_o, ex_valid_o, flush_o;
  logic [CAUSE_W-1:0]        ex_cause_o;
  logic [TVAL_W-1:0]         ex_tval_o;
  logic                      dcache_flush_req_o, dcache_flush_ack_i;
  logic [PERF_ADDR_W-1:0]    perf_addr_i;
  logic [CntWidth-1:0]       perf_rdata_o;

  // Bookkeeping and the retirement model
  int            errors = 0, test_errors = 0, tests_run = 0, tests_failed = 0;
  int            model_instret = 0, model_exc = 0;
  int unsigned   ack_delay = 0;
  string         cur_test = "startup";
  logic          chk_en = 1'b0, cyc_en = 1'b0;
  logic [CntWidth-1:0] chk_exp = '0, cyc_floor = '0;

  wire ret_res   = commit_valid_i && commit_ack_o && (commit_op_i == OP_RESULT);
  wire ret_exc   = commit_valid_i && commit_ack_o && (commit_op_i == OP_EXC);
  wire ret_fence = commit_valid_i && commit_ack_o && (commit_op_i == OP_FENCE);

  commit_top #(.CntWidth(CntWidth)) commit_top_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  assert property (@(posedge clk_i) $rose(rst_ni) |->
    {commit_ack_o, we_o, ex_valid_o, flush_o, dcache_flush_req_o} == '0)
    else report_mismatch("outputs after reset", '0,
      $sampled({commit_ack_o, we_o, ex_valid_o, flush_o, dcache_flush_req_o}));

  assert property (@(posedge clk_i) disable iff (!rst_ni) ret_res |->
    {we_o, waddr_o, wdata_o, ex_valid_o} ==
    {commit_waddr_i != '0, commit_waddr_i, commit_payload_i, 1'b0})
    else report_mismatch("result writeback",
      $sampled({commit_waddr_i != '0, commit_waddr_i, commit_payload_i, 1'b0}),
      $sampled({we_o, waddr_o, wdata_o, ex_valid_o}));

  // Cause and tval split the payload word top to bottom
  assert property (@(posedge clk_i) disable iff (!rst_ni) ret_exc |->
    {ex_valid_o, ex_cause_o, ex_tval_o, we_o} == {1'b1, commit_payload_i, 1'b0})
    else report_mismatch("exception report", $sampled({1'b1, commit_payload_i, 1'b0}),
      $sampled({ex_valid_o, ex_cause_o, ex_tval_o, we_o}));

  assert property (@(posedge clk_i) disable iff (!rst_ni) ret_exc |=> flush_o && !commit_ack_o)
    else report_mismatch("flush and ack after exception", 2'b10,
      $sampled({flush_o, commit_ack_o}));

  assert property (@(posedge clk_i) disable iff (!rst_ni) flush_o |-> $past(ret_exc))
    else fail_note("flush_o high without an exception in the cycle before");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    dcache_flush_req_o && !dcache_flush_ack_i |=> dcache_flush_req_o)
    else fail_note("cache flush request dropped before its ack");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    dcache_flush_req_o |-> !$past(dcache_flush_ack_i))
    else fail_note("cache flush request high again before the ack fell");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    ret_fence |-> !dcache_flush_ack_i && $past(dcache_flush_ack_i))
    else fail_note("fence acked before the cache flush ack fell");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_ack_o |-> !dcache_flush_req_o && !dcache_flush_ack_i)
    else fail_note("entry acked while the cache flush was busy");

  assert property (@(posedge clk_i) chk_en |-> perf_rdata_o == chk_exp)
    else report_mismatch($sformatf("counter %0d", $sampled(perf_addr_i)),
      $sampled(chk_exp), $sampled(perf_rdata_o));

  assert property (@(posedge clk_i) cyc_en |-> perf_rdata_o > cyc_floor)
    else report_mismatch("cycle count above", $sampled(cyc_floor), $sampled(perf_rdata_o));

  // --------------------------------------------------
  // Data cache side of the flush handshake
  // --------------------------------------------------
  initial begin
    int unsigned n;
    forever begin
      @(negedge clk_i);
      if (dcache_flush_req_o && !dcache_flush_ack_i) begin
        repeat (ack_delay) @(posedge clk_i);
        @(posedge clk_i);
        #1 dcache_flush_ack_i = 1'b1;
        n = 0;
        while (dcache_flush_req_o && n < TimeoutCycles) begin
          @(negedge clk_i);
          n++;
        end
        if (dcache_flush_req_o) begin
          abort_run("cache flush request never dropped after the ack");
        end else begin
          repeat (ack_delay) @(posedge clk_i);
          @(posedge clk_i);
          #1 dcache_flush_ack_i = 1'b0;
        end
      end
    end
  end

  task automatic finish_run();
    $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  endtask

  `include "commit_tb_tests.svh"

  initial begin
    void'($urandom(32'h6cf56e93));
    rst_ni             = 1'b0;
    commit_valid_i     = 1'b0;
    commit_op_i        = OP_RESULT;
    commit_waddr_i     = '0;
    commit_payload_i   = '0;
    dcache_flush_ack_i = 1'b0;
    perf_addr_i        = PERF_CYCLE;
    repeat (3) @(posedge clk_i);
    #1;
    check_reset();
    run_entries("result_entries", 20, OP_RESULT, 1'b0);
    run_entries("exception_entries", 15, OP_EXC, 1'b0);
    run_entries("fence_entries", 10, OP_FENCE, 1'b0);
    run_entries("random_mix", 200, OP_RESULT, 1'b1);
    check_counters();
    finish_run();
  end

endmodule

/* verilog/commit_ctrl_if.sv */
// Control lines between the commit stage, the flush controller and the counters.

`timescale 1ns/1ps

interface commit_ctrl_if;

  // Commit stage to flush controller
  logic fence_req;
  logic ex_valid;

  // Flush controller to commit stage
  logic fence_done;
  logic halt;

  // Retirement events for the counters
  logic retire;
  logic ex_retire;

  modport stage (
    output fence_req,
    output ex_valid,
    output retire,
    output ex_retire,
    input  fence_done,
    input  halt
  );

  modport ctrl (
    input  fence_req,
    input  ex_valid,
    output fence_done,
    output halt
  );

  modport perf (
    input  retire,
    input  ex_retire
  );

endinterface

/* verilog/commit_pkg.sv */
// Shared widths and encodings for the commit path.
// The payload word is decoded as a result or as an exception cause with tval.

package commit_pkg;

  // --------------------------------------------------
  // Widths
  // --------------------------------------------------
  localparam int unsigned DATA_W      = 32;
  localparam int unsigned REG_ADDR_W  = 5;
  localparam int unsigned OP_W        = 2;
  localparam int unsigned CAUSE_W     = 4;
  localparam int unsigned TVAL_W      = 28;
  localparam int unsigned PERF_ADDR_W = 2;

  // Entry kinds at the head of the scoreboard
  localparam logic [OP_W-1:0] OP_RESULT = 2'd0;
  localparam logic [OP_W-1:0] OP_EXC    = 2'd1;
  localparam logic [OP_W-1:0] OP_FENCE  = 2'd2;

  // Counter select codes
  localparam logic [PERF_ADDR_W-1:0] PERF_CYCLE   = 2'd0;
  localparam logic [PERF_ADDR_W-1:0] PERF_INSTRET = 2'd1;
  localparam logic [PERF_ADDR_W-1:0] PERF_EXC     = 2'd2;

  // --------------------------------------------------
  // Payload word
  // --------------------------------------------------
  // Cause sits in the top bits, tval fills the rest
  typedef struct packed {
    logic [CAUSE_W-1:0] cause;
    logic [TVAL_W-1:0]  tval;
  } exc_payload_t;

  typedef union packed {
    logic [DATA_W-1:0] result;
    exc_payload_t      exc;
  } commit_payload_u;

endpackage

/* verilog/commit_stage.sv */
// Single-entry in-order commit. The head entry must stay stable until acked.
// Op code 3 is not defined and retires silently without any side effect.

`timescale 1ns/1ps

module commit_stage (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                commit_valid_i,
  input  logic [commit_pkg::OP_W-1:0]         commit_op_i,
  input  logic [commit_pkg::REG_ADDR_W-1:0]   commit_waddr_i,
  input  commit_pkg::commit_payload_u         commit_payload_i,
  output logic                                commit_ack_o,
  output logic                                we_o,
  output logic [commit_pkg::REG_ADDR_W-1:0]   waddr_o,
  output logic [commit_pkg::DATA_W-1:0]       wdata_o,
  output logic                                ex_valid_o,
  output logic [commit_pkg::CAUSE_W-1:0]      ex_cause_o,
  output logic [commit_pkg::TVAL_W-1:0]       ex_tval_o,
  commit_ctrl_if.stage                        ctrl
);

  import commit_pkg::*;

  logic is_result;
  logic is_exc;
  logic is_fence;
  logic is_other;

  // --------------------------------------------------
  // Decode the head entry
  // --------------------------------------------------
  assign is_result = commit_valid_i && (commit_op_i == OP_RESULT);
  assign is_exc    = commit_valid_i && (commit_op_i == OP_EXC);
  assign is_fence  = commit_valid_i && (commit_op_i == OP_FENCE);
  assign is_other  = commit_valid_i && !is_result && !is_exc && !is_fence;

  // Fences wait for the cache flush, everything else only for halt
  always_comb begin
    commit_ack_o = 1'b0;
    if (is_fence) begin
      commit_ack_o = ctrl.fence_done;
    end else if (is_result || is_exc || is_other) begin
      commit_ack_o = !ctrl.halt;
    end
  end

  // --------------------------------------------------
  // Writeback and exception views of the payload
  // --------------------------------------------------
  // x0 is hardwired, so no write for it
  assign we_o    = is_result && !ctrl.halt && (commit_waddr_i != '0);
  assign waddr_o = commit_waddr_i;
  assign wdata_o = commit_payload_i.result;

  assign ex_valid_o = is_exc && !ctrl.halt;
  assign ex_cause_o = commit_payload_i.exc.cause;
  assign ex_tval_o  = commit_payload_i.exc.tval;

  // Requests to the flush controller
  assign ctrl.fence_req = is_fence;
  assign ctrl.ex_valid  = ex_valid_o;

  // Events for the counters
  assign ctrl.retire    = commit_ack_o && (is_result || is_fence);
  assign ctrl.ex_retire = commit_ack_o && is_exc;

  // --------------------------------------------------
  // Assertions
  // --------------------------------------------------
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_ack_o |-> commit_valid_i)
    else $error("commit ack without a valid entry");

  // A retired exception halts the head for the flush cycle
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    ctrl.ex_retire |=> ctrl.halt && !commit_ack_o)
    else $error("entry acked in the cycle after an exception");

endmodule

/* verilog/commit_top.sv */
// Commit and flush control top level. One entry is presented at a time and is
// held stable by the source until commit_ack_o is seen high.

`timescale 1ns/1ps

module commit_top #(
  parameter int unsigned CntWidth = 32
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  // Head of the scoreboard
  input  logic                                 commit_valid_i,
  input  logic [commit_pkg::OP_W-1:0]          commit_op_i,
  input  logic [commit_pkg::REG_ADDR_W-1:0]    commit_waddr_i,
  input  logic [commit_pkg::DATA_W-1:0]        commit_payload_i,
  output logic                                 commit_ack_o,
  // Register file write
  output logic                                 we_o,
  output logic [commit_pkg::REG_ADDR_W-1:0]    waddr_o,
  output logic [commit_pkg::DATA_W-1:0]        wdata_o,
  // Exception report
  output logic                                 ex_valid_o,
  output logic [commit_pkg::CAUSE_W-1:0]       ex_cause_o,
  output logic [commit_pkg::TVAL_W-1:0]        ex_tval_o,
  // Pipeline and data cache flush
  output logic                                 flush_o,
  output logic                                 dcache_flush_req_o,
  input  logic                                 dcache_flush_ack_i,
  // Counter read port
  input  logic [commit_pkg::PERF_ADDR_W-1:0]   perf_addr_i,
  output logic [CntWidth-1:0]                  perf_rdata_o
);

  commit_ctrl_if ctrl_if ();

  // --------------------------------------------------
  // Commit stage
  // --------------------------------------------------
  commit_stage commit_stage_i (
    .clk_i            ( clk_i            ),
    .rst_ni           ( rst_ni           ),
    .commit_valid_i   ( commit_valid_i   ),
    .commit_op_i      ( commit_op_i      ),
    .commit_waddr_i   ( commit_waddr_i   ),
    .commit_payload_i ( commit_payload_i ),
    .commit_ack_o     ( commit_ack_o     ),
    .we_o             ( we_o             ),
    .waddr_o          ( waddr_o          ),
    .wdata_o          ( wdata_o          ),
    .ex_valid_o       ( ex_valid_o       ),
    .ex_cause_o       ( ex_cause_o       ),
    .ex_tval_o        ( ex_tval_o        ),
    .ctrl             ( ctrl_if.stage    )
  );

  // --------------------------------------------------
  // Flush controller
  // --------------------------------------------------
  flush_ctrl flush_ctrl_i (
    .clk_i              ( clk_i              ),
    .rst_ni             ( rst_ni             ),
    .dcache_flush_req_o ( dcache_flush_req_o ),
    .dcache_flush_ack_i ( dcache_flush_ack_i ),
    .flush_o            ( flush_o            ),
    .ctrl               ( ctrl_if.ctrl       )
  );

  // --------------------------------------------------
  // Performance counters
  // --------------------------------------------------
  perf_counters #(
    .CntWidth ( CntWidth )
  ) perf_counters_i (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .perf_addr_i  ( perf_addr_i  ),
    .perf_rdata_o ( perf_rdata_o ),
    .ctrl         ( ctrl_if.perf )
  );

endmodule

/* verilog/flush_ctrl.sv */
// Flush FSM. One exception flush cycle, or a four-phase req/ack cache flush per fence.
// The cache side must raise ack only while req is high and drop it only after req drops.

`timescale 1ns/1ps

module flush_ctrl (
  input  logic   clk_i,
  input  logic   rst_ni,
  output logic   dcache_flush_req_o,
  input  logic   dcache_flush_ack_i,
  output logic   flush_o,
  commit_ctrl_if.ctrl ctrl
);

  // State encoding
  localparam logic [1:0] IDLE           = 2'd0;
  localparam logic [1:0] FLUSH          = 2'd1;
  localparam logic [1:0] FENCE_REQ      = 2'd2;
  localparam logic [1:0] FENCE_WAIT_LOW = 2'd3;

  logic [1:0] state_q;
  logic [1:0] state_d;

  // --------------------------------------------------
  // Next state
  // --------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        // Exception wins, both cannot be at the head at once anyway
        if (ctrl.ex_valid) begin
          state_d = FLUSH;
        end else if (ctrl.fence_req) begin
          state_d = FENCE_REQ;
        end
      end
      FLUSH: begin
        state_d = IDLE;
      end
      FENCE_REQ: begin
        if (dcache_flush_ack_i) begin
          state_d = FENCE_WAIT_LOW;
        end
      end
      FENCE_WAIT_LOW: begin
        if (!dcache_flush_ack_i) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // --------------------------------------------------
  // Outputs
  // --------------------------------------------------
  assign flush_o            = (state_q == FLUSH);
  assign ctrl.halt          = (state_q == FLUSH);
  assign dcache_flush_req_o = (state_q == FENCE_REQ);
  // Last phase of the handshake, the fence retires here
  assign ctrl.fence_done    = (state_q == FENCE_WAIT_LOW) && !dcache_flush_ack_i;

  // --------------------------------------------------
  // Assertions
  // --------------------------------------------------
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    dcache_flush_req_o && !dcache_flush_ack_i |=> dcache_flush_req_o)
    else $error("cache flush request dropped before ack");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == FLUSH) |=> (state_q != FLUSH))
    else $error("exception flush longer than one cycle");

endmodule

/* verilog/perf_counters.sv */
// Cycle, retired-instruction and exception counters. Read only, they wrap on overflow.
// Each counter updates one cycle after its event.

`timescale 1ns/1ps

module perf_counters #(
  parameter int unsigned CntWidth = 32
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic [commit_pkg::PERF_ADDR_W-1:0]   perf_addr_i,
  output logic [CntWidth-1:0]                  perf_rdata_o,
  commit_ctrl_if.perf                          ctrl
);

  import commit_pkg::*;

  logic [CntWidth-1:0] cycle_q;
  logic [CntWidth-1:0] instret_q;
  logic [CntWidth-1:0] exc_q;

  // --------------------------------------------------
  // Counters
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cycle_q   <= '0;
      instret_q <= '0;
      exc_q     <= '0;
    end else begin
      cycle_q <= cycle_q + 1'b1;
      if (ctrl.retire) begin
        instret_q <= instret_q + 1'b1;
      end
      if (ctrl.ex_retire) begin
        exc_q <= exc_q + 1'b1;
      end
    end
  end

  // Read port, unused codes read as zero
  always_comb begin
    case (perf_addr_i)
      PERF_CYCLE:   perf_rdata_o = cycle_q;
      PERF_INSTRET: perf_rdata_o = instret_q;
      PERF_EXC:     perf_rdata_o = exc_q;
      default:      perf_rdata_o = '0;
    endcase
  end

endmodule
